// File: motion_ctrl.f
design/motion_pkg.sv
design/step_accumulator.sv
design/move_sequencer.sv
design/word_cmd_decoder.sv
design/motion_ctrl_top.sv
verification/motion_ctrl_asserts.sv
verification/motion_ctrl_checker.sv
verification/motion_ctrl_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! command -v verilator > /dev/null; then
  echo "verilator not found"
  exit 1
fi

verilator --binary --assert -Wno-fatal --top-module motion_ctrl_tb \
  -f motion_ctrl.f --Mdir obj_dir -o motion_ctrl_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/motion_ctrl_sim +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1

// File: verification/motion_ctrl_tb.sv
// Testbench top that applies a table of host commands to the motion controller and reports
module motion_ctrl_tb
  import motion_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum logic [1:0] {kind_status, kind_config, kind_move} test_kind_t;

  logic        CLK = 1'b0;
  logic        resetn;
  word_t       word_data_received;
  logic        word_received;
  word_t       word_send_data;
  logic        buffer_dtr;
  logic        move_done;
  motor_mask_t step_out;
  motor_mask_t dir_out;
  motor_mask_t enable_out;
  int unsigned moves_done;

  string       test_name  [$];
  test_kind_t  test_kind  [$];
  word_t       test_reply [$]; // Expected reply to the first word of each test
  int          test_first [$];
  int          test_len   [$];
  word_t       test_words [$];
  logic [31:0] lfsr_state = 32'h1f77dda5;
  int unsigned wait_limit = 2000;
  int unsigned moves_sent = 0;
  motor_mask_t exp_enable = '0;

  always #20 CLK = ~CLK;

  motion_ctrl_top i_motion_ctrl_top (.*);

  motion_ctrl_checker i_motion_ctrl_checker (.*);

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic word_t random_bits(input int count);
    word_t value;
    logic  feedback;
    value = '0;
    for (int i = 0; i < count; i++) begin
      feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], feedback};
      value      = {value[WORD_BITS-2:0], feedback};
    end
    return value;
  endfunction

  // Second-order DDA reference with one step per change of STEP_BIT
  function automatic int unsigned expected_steps(input word_t increment, input word_t incr_incr,
                                                 input duration_t duration);
    logic [63:0] position;
    logic [63:0] speed;
    logic [63:0] next_pos;
    int unsigned count;
    position = '0;
    speed    = increment;
    count    = 0;
    for (longint t = 0; t < longint'(duration); t++) begin
      next_pos = position + speed;
      if (next_pos[STEP_BIT] != position[STEP_BIT]) count++;
      position = next_pos;
      speed    = speed + incr_incr;
    end
    return count;
  endfunction

  function automatic word_t cmd_word(input header_t header, input word_t low);
    return {header, low[WORD_BITS-9:0]};
  endfunction

  task automatic add_test(input string name, input test_kind_t kind, input word_t reply);
    test_name.push_back(name);
    test_kind.push_back(kind);
    test_reply.push_back(reply);
    test_first.push_back(test_words.size());
    test_len.push_back(0);
  endtask

  task automatic add_word(input word_t w);
    test_words.push_back(w);
    test_len[test_len.size() - 1] += 1;
  endtask

  task automatic add_move(input motor_mask_t dir, input duration_t duration, input int ii_bits);
    add_word(cmd_word(CMD_COORDINATED_STEP, word_t'(dir)));
    add_word(word_t'(duration));
    for (int m = 0; m < NUM_MOTORS; m++) begin
      add_word(random_bits(31)); // At most half a step per tick
      add_word(ii_bits > 0 ? random_bits(ii_bits) : '0);
    end
  endtask

  task automatic build_table();
    add_test("status_version", kind_status, word_t'(VERSION_WORD));
    add_word(cmd_word(CMD_STATUS_REG, word_t'(STATUS_VERSION)));
    add_test("status_channel_info", kind_status, word_t'(NUM_MOTORS));
    add_word(cmd_word(CMD_STATUS_REG, word_t'(STATUS_CHANNEL_INFO)));
    add_test("status_unused_address", kind_status, '0);
    add_word(cmd_word(CMD_STATUS_REG, 64'd5));
    add_test("config_divisor_default", kind_config, 64'd32);
    add_word(cmd_word(CMD_CONFIG_REG, word_t'(CONFIG_CLOCKS)));
    add_word(64'd1);                                  // Tick every second cycle from here on
    add_test("config_enable_write", kind_config, '0);
    add_word(cmd_word(CMD_CONFIG_REG, word_t'(CONFIG_ENABLE)));
    add_word(64'h3);
    add_test("config_enable_read", kind_config, 64'h3);
    add_word(cmd_word(CMD_CONFIG_REG, word_t'(CONFIG_ENABLE)));
    add_word(64'h3);
    add_test("unknown_header", kind_status, '0);
    add_word(cmd_word(8'h5a, 64'd1));
    add_test("status_after_unknown", kind_status, word_t'(VERSION_WORD));
    add_word(cmd_word(CMD_STATUS_REG, word_t'(STATUS_VERSION)));
    add_test("move_constant_speed", kind_move, '0);
    add_move(2'b10, 40, 0);
    add_test("move_accelerating", kind_move, '0);
    add_move(2'b01, 48, 26);
    add_test("move_back_to_back", kind_move, '0);
    add_move(2'b11, 30, 24);
    add_move(2'b00, 36, 24);
  endtask

  // Hold the word and strobe it for two cycles, then read the reply four cycles later
  task automatic send_word(input word_t w);
    @(posedge CLK);
    word_data_received <= w;
    word_received      <= 1'b1;
    repeat (2) @(posedge CLK);
    word_received <= 1'b0;
    repeat (2) @(posedge CLK);
    @(negedge CLK);
  endtask

  task automatic wait_for_dtr(output logic ok);
    ok = 1'b0;
    for (int c = 0; c < wait_limit && !ok; c++) begin
      @(negedge CLK);
      ok = buffer_dtr;
    end
    if (!ok) i_motion_ctrl_checker.note_failure("timed out waiting for buffer_dtr");
  endtask

  task automatic wait_for_moves(input int unsigned target, output logic ok);
    ok = 1'b0;
    for (int c = 0; c < wait_limit && !ok; c++) begin
      @(negedge CLK);
      ok = moves_done >= target;
    end
    if (!ok) i_motion_ctrl_checker.note_failure("timed out waiting for move_done");
  endtask

  task automatic run_register_test(input int t);
    for (int i = 0; i < test_len[t]; i++) begin
      send_word(test_words[test_first[t] + i]);
      i_motion_ctrl_checker.check_reply(i == 0 ? test_reply[t] : '0);
    end
    if (test_kind[t] == kind_config && test_len[t] == 2 &&
        test_words[test_first[t]][7:0] == CONFIG_ENABLE) begin
      exp_enable = test_words[test_first[t] + 1][NUM_MOTORS-1:0];
    end
    i_motion_ctrl_checker.check_enable(exp_enable);
  endtask

  task automatic run_move_test(input int t, output logic ok);
    int                          n_moves;
    int                          base;
    logic [NUM_MOTORS-1:0][31:0] steps;
    n_moves = test_len[t] / (1 + MOVE_WORDS);
    ok      = 1'b1;
    for (int k = 0; k < n_moves && ok; k++) begin
      wait_for_dtr(ok);
      for (int i = 0; i <= MOVE_WORDS && ok; i++) begin
        send_word(test_words[test_first[t] + k * (1 + MOVE_WORDS) + i]);
        i_motion_ctrl_checker.check_reply('0);
      end
      if (ok) begin
        moves_sent++;
        // buffer_dtr drops once every slot holds an unfinished move
        i_motion_ctrl_checker.check_dtr(moves_sent - moves_done < BUFFER_SLOTS);
      end
    end
    if (ok) wait_for_moves(moves_sent, ok);
    for (int k = 0; k < n_moves && ok; k++) begin
      base = test_first[t] + k * (1 + MOVE_WORDS);
      for (int m = 0; m < NUM_MOTORS; m++) begin
        steps[m] = expected_steps(test_words[base + 2 + 2 * m], test_words[base + 3 + 2 * m],
                                  test_words[base + 1][DURATION_BITS-1:0]);
      end
      i_motion_ctrl_checker.check_move(test_words[base][NUM_MOTORS-1:0], steps);
    end
  endtask

  initial begin
    logic        ok;
    logic        timed_out;
    int unsigned assert_failures;
    int unsigned total_errors;
    resetn             = 1'b1;
    word_received      = 1'b0;
    word_data_received = '0;
    timed_out          = 1'b0;
    build_table();
    repeat (8) @(posedge CLK);
    resetn <= 1'b0;
    for (int t = 0; t < test_name.size() && !timed_out; t++) begin
      i_motion_ctrl_checker.begin_test(test_name[t]);
      ok = 1'b1;
      if (test_kind[t] == kind_move) begin
        run_move_test(t, ok);
      end else begin
        run_register_test(t);
      end
      i_motion_ctrl_checker.end_test();
      timed_out = !ok;
    end
    assert_failures = i_motion_ctrl_top.i_move_sequencer.i_motion_ctrl_asserts.failures;
    i_motion_ctrl_checker.summary(assert_failures, total_errors);
    if (!timed_out && total_errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: verification/motion_ctrl_checker.sv
// Watches the DUT ports and compares replies, enables, buffer_dtr and per-move step counts
module motion_ctrl_checker
  import motion_pkg::*;
(
  input  logic        CLK,
  input  logic        resetn,
  input  word_t       word_send_data,
  input  logic        buffer_dtr,
  input  logic        move_done,
  input  motor_mask_t step_out,
  input  motor_mask_t dir_out,
  input  motor_mask_t enable_out,
  output int unsigned moves_done
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    motor_mask_t                 dir;
    logic [NUM_MOTORS-1:0][31:0] steps;
  } move_result_t;

  move_result_t                results [$];
  logic [NUM_MOTORS-1:0][31:0] step_count;
  motor_mask_t                 last_dir;
  string                       current_test;
  int unsigned                 test_errors;
  int unsigned                 checks = 0;
  int unsigned                 errors = 0;
  int unsigned                 tests_run = 0;
  int unsigned                 tests_failed = 0;

  // Steps seen up to a move_done belong to that move
  always @(negedge CLK) begin
    if (resetn) begin
      step_count = '0;
      moves_done <= 0;
    end else begin
      for (int m = 0; m < NUM_MOTORS; m++) begin
        if (step_out[m]) step_count[m] = step_count[m] + 1;
      end
      if (move_done) begin
        results.push_back(move_result_t'({last_dir, step_count}));
        step_count = '0;
        moves_done <= moves_done + 1;
      end else begin
        last_dir = dir_out; // move_index advances with move_done
      end
    end
  end

  task automatic begin_test(input string name);
    current_test = name;
    test_errors  = 0;
  endtask

  task automatic compare(input string what, input word_t expected, input word_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("error %s/%s expected %0h actual %0h", current_test, what, expected, actual);
    end
  endtask

  task automatic note_failure(input string what);
    errors++;
    test_errors++;
    $display("%s in test %s", what, current_test);
  endtask

  task automatic check_reply(input word_t expected);
    compare("reply", expected, word_send_data);
  endtask

  task automatic check_enable(input motor_mask_t expected);
    compare("enable_out", word_t'(expected), word_t'(enable_out));
  endtask

  task automatic check_dtr(input logic expected);
    compare("buffer_dtr", word_t'(expected), word_t'(buffer_dtr));
  endtask

  task automatic check_move(input motor_mask_t dir, input logic [NUM_MOTORS-1:0][31:0] steps);
    move_result_t got;
    if (results.size() == 0) begin
      note_failure("no finished move to compare");
    end else begin
      got = results.pop_front();
      compare("dir_out", word_t'(dir), word_t'(got.dir));
      for (int m = 0; m < NUM_MOTORS; m++) begin
        compare($sformatf("steps%0d", m), word_t'(steps[m]), word_t'(got.steps[m]));
      end
    end
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("ok %s", current_test);
    end else begin
      tests_failed++;
      $display("failed %s with %0d errors", current_test, test_errors);
    end
  endtask

  task automatic summary(input int unsigned assert_failures, output int unsigned total);
    total = errors + assert_failures;
    $display("tests %0d failed %0d checks %0d errors %0d assertion failures %0d",
             tests_run, tests_failed, checks, errors, assert_failures);
  endtask

endmodule

// File: verification/motion_ctrl_asserts.sv
// Concurrent checks on the move sequencer outputs, attached to every move_sequencer by bind
module motion_ctrl_asserts (
  input logic CLK,
  input logic resetn,
  input logic tick,
  input logic load_move,
  input logic move_done,
  input logic buffer_dtr
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned failures = 0; // Tally picked up by the testbench top

  done_one_cycle: assert property (@(posedge CLK) disable iff (resetn)
    move_done |=> !move_done)
    else begin
      failures++;
      $error("move_done high for more than one cycle");
    end

  // No tick or new load in the completion cycle
  done_alone: assert property (@(posedge CLK) disable iff (resetn)
    move_done |-> !(tick || load_move))
    else begin
      failures++;
      $error("tick or load_move high together with move_done");
    end

  reset_values: assert property (@(posedge CLK) resetn |=> (buffer_dtr && !move_done))
    else begin
      failures++;
      $error("buffer_dtr low or move_done high after reset");
    end

endmodule

bind move_sequencer motion_ctrl_asserts i_motion_ctrl_asserts (
  .CLK        (CLK),
  .resetn     (resetn),
  .tick       (tick),
  .load_move  (load_move),
  .move_done  (move_done),
  .buffer_dtr (buffer_dtr)
);

// File: design/motion_ctrl_top.sv
// Top level of the motion controller, connecting word decoder, move sequencer and the DDA axes
module motion_ctrl_top
  import motion_pkg::*;
(
  input  logic        CLK,
  input  logic        resetn,
  input  word_t       word_data_received,
  input  logic        word_received,
  output word_t       word_send_data,
  output logic        buffer_dtr,
  output logic        move_done,
  output motor_mask_t step_out,
  output motor_mask_t dir_out,
  output motor_mask_t enable_out
);

  move_cmd_t               active_move;
  logic [BUFFER_SLOTS-1:0] slot_ready;
  divisor_t                divisor;
  slot_t                   move_index;
  logic                    tick;
  logic                    load_move;
  logic                    executing;

  word_cmd_decoder i_word_cmd_decoder (
    .CLK                (CLK),
    .resetn             (resetn),
    .word_data_received (word_data_received),
    .word_received      (word_received),
    .move_index         (move_index),
    .word_send_data     (word_send_data),
    .active_move        (active_move),
    .slot_ready         (slot_ready),
    .divisor            (divisor),
    .enable_mask        (enable_out)
  );

  move_sequencer i_move_sequencer (
    .CLK        (CLK),
    .resetn     (resetn),
    .divisor    (divisor),
    .slot_ready (slot_ready),
    .duration   (active_move.duration),
    .tick       (tick),
    .load_move  (load_move),
    .executing  (executing),
    .move_done  (move_done),
    .move_index (move_index),
    .buffer_dtr (buffer_dtr)
  );

  // One DDA per motor, all sharing the sequencer timing
  for (genvar m = 0; m < NUM_MOTORS; m++) begin : g_axis
    step_accumulator i_step_accumulator (
      .CLK       (CLK),
      .resetn    (resetn),
      .tick      (tick),
      .load_move (load_move),
      .executing (executing),
      .axis      (active_move.axis[m]),
      .step      (step_out[m])
    );
  end

  assign dir_out = active_move.dir; // Follows the slot being executed

endmodule

// File: design/word_cmd_decoder.sv
// Host word decoder: finds word strobes, answers status and config reads, fills the move buffer
module word_cmd_decoder
  import motion_pkg::*;
(
  input  logic                    CLK,
  input  logic                    resetn,
  input  word_t                   word_data_received,
  input  logic                    word_received,
  input  slot_t                   move_index,
  output word_t                   word_send_data,
  output move_cmd_t               active_move,
  output logic [BUFFER_SLOTS-1:0] slot_ready,
  output divisor_t                divisor,
  output motor_mask_t             enable_mask
);

  logic                       word_received_q;
  logic                       word_received_qq;
  logic                       word_edge;
  dec_state_t                 state;
  header_t                    header;
  reg_addr_t                  word_addr;
  reg_addr_t                  cfg_addr;
  logic [MOVE_COUNT_BITS-1:0] word_cnt;
  logic [MOVE_COUNT_BITS-1:0] axis_word;
  logic [MOVE_COUNT_BITS-1:0] axis_sel;
  slot_t                      wr_index;
  motor_mask_t                cfg_enable;
  divisor_t                   cfg_divisor;
  word_t                      status_value;
  word_t                      config_value;
  move_cmd_t                  move_buf [BUFFER_SLOTS];

  assign word_edge = word_received_q & ~word_received_qq;
  assign header    = word_data_received[WORD_BITS-1 -: 8]; // Header is the top byte
  assign word_addr = word_data_received[7:0];
  assign axis_word = word_cnt - 1'b1;
  assign axis_sel  = axis_word >> 1;                     // Two words per motor

  always_comb begin
    case (word_addr)
      STATUS_VERSION:      status_value = word_t'(VERSION_WORD);
      STATUS_CHANNEL_INFO: status_value = word_t'(NUM_MOTORS); // Motor count, no encoders
      default:             status_value = '0;
    endcase
  end

  always_comb begin
    case (word_addr)
      CONFIG_ENABLE: config_value = word_t'(cfg_enable);
      CONFIG_CLOCKS: config_value = word_t'(cfg_divisor);
      default:       config_value = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      word_received_q  <= 1'b0;
      word_received_qq <= 1'b0;
      state            <= idle;
      word_cnt         <= '0;
      wr_index         <= '0;
      slot_ready       <= '0;
      word_send_data   <= '0;
      cfg_enable       <= '0;
      cfg_divisor      <= DEFAULT_DIVISOR;
    end else begin
      word_received_q  <= word_received;
      word_received_qq <= word_received_q;
      if (word_edge) begin
        word_send_data <= '0; // Move data and config writes reply zero
        case (state)
          idle: begin
            case (header)
              CMD_STATUS_REG: word_send_data <= status_value;
              CMD_CONFIG_REG: begin
                cfg_addr       <= word_addr;
                word_send_data <= config_value;
                state          <= config_data;
              end
              CMD_COORDINATED_STEP: begin
                word_cnt <= '0;
                state    <= move_data;
              end
              default: word_send_data <= '0; // Unknown header, stay idle
            endcase
          end
          move_data: begin
            word_cnt <= word_cnt + 1'b1;
            if (word_cnt == MOVE_COUNT_BITS'(MOVE_WORDS - 1)) begin
              // Last word lands this cycle, hand the slot to the sequencer
              slot_ready[wr_index] <= ~slot_ready[wr_index];
              wr_index             <= wr_index + 1'b1;
              state                <= idle;
            end
          end
          config_data: begin
            case (cfg_addr)
              CONFIG_ENABLE: cfg_enable  <= word_data_received[NUM_MOTORS-1:0];
              CONFIG_CLOCKS: cfg_divisor <= word_data_received[DIVISOR_BITS-1:0];
              default:       cfg_enable  <= cfg_enable; // Read-only zero
            endcase
            state <= idle;
          end
          default: state <= idle;
        endcase
      end
    end
  end

  // Move buffer fields are written in place as their words arrive
  always_ff @(posedge CLK) begin
    if (word_edge && state == idle && header == CMD_COORDINATED_STEP) begin
      move_buf[wr_index].dir <= word_data_received[NUM_MOTORS-1:0];
    end
    if (word_edge && state == move_data) begin
      if (word_cnt == '0) begin
        move_buf[wr_index].duration <= word_data_received[DURATION_BITS-1:0];
      end else if (!axis_word[0]) begin
        move_buf[wr_index].axis[axis_sel].increment <= word_data_received;
      end else begin
        move_buf[wr_index].axis[axis_sel].incr_incr <= word_data_received;
      end
    end
  end

  assign active_move = move_buf[move_index];
  assign divisor     = cfg_divisor;
  assign enable_mask = cfg_enable;

endmodule

// File: design/move_sequencer.sv
// Tick divider and move sequencer: takes ready buffer slots in order and times each move in ticks
module move_sequencer
  import motion_pkg::*;
(
  input  logic                    CLK,
  input  logic                    resetn,
  input  divisor_t                divisor,
  input  logic [BUFFER_SLOTS-1:0] slot_ready,
  input  duration_t               duration,
  output logic                    tick,
  output logic                    load_move,
  output logic                    executing,
  output logic                    move_done,
  output slot_t                   move_index,
  output logic                    buffer_dtr
);

  divisor_t                div_cnt;
  duration_t               remaining;
  logic [BUFFER_SLOTS-1:0] consumed;
  logic [BUFFER_SLOTS-1:0] pending;
  logic                    busy;
  logic                    finishing;
  logic                    finish;

  assign pending = slot_ready ^ consumed; // Slot written but not yet run
  assign finish  = (load_move && duration == '0) || finishing;

  // Divider holds off a tick on the move_done cycle
  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt <= '0;
      tick    <= 1'b0;
    end else if (div_cnt >= divisor) begin
      tick <= !finish;
      if (!finish) div_cnt <= '0;
    end else begin
      tick    <= 1'b0;
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      load_move  <= 1'b0;
      executing  <= 1'b0;
      move_done  <= 1'b0;
      finishing  <= 1'b0;
      busy       <= 1'b0;
      consumed   <= '0;
      move_index <= '0;
      buffer_dtr <= 1'b1;
    end else begin
      load_move  <= 1'b0;
      move_done  <= 1'b0;
      finishing  <= 1'b0;
      buffer_dtr <= ~&pending;
      if (!busy && pending[move_index]) begin
        busy      <= 1'b1;
        load_move <= 1'b1;
      end else if (load_move) begin
        remaining <= duration;
        executing <= duration != '0;
      end else if (executing && tick) begin
        remaining <= remaining - 1'b1;
        if (remaining == duration_t'(1)) begin
          executing <= 1'b0;
          finishing <= 1'b1; // Last step pulse settles before move_done
        end
      end
      if (finish) begin
        move_done            <= 1'b1;
        busy                 <= 1'b0;
        consumed[move_index] <= ~consumed[move_index];
        move_index           <= move_index + 1'b1;
      end
    end
  end

endmodule

// File: design/step_accumulator.sv
// Second-order DDA for one motor, pulsing step whenever the integer step position changes
module step_accumulator
  import motion_pkg::*;
(
  input  logic      CLK,
  input  logic      resetn,
  input  logic      tick,
  input  logic      load_move,
  input  logic      executing,
  input  axis_cmd_t axis,
  output logic      step
);

  dda_t accum;
  dda_t velocity;
  dda_t accum_next;

  assign accum_next = accum + velocity;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      step <= 1'b0;
    end else begin
      step <= 1'b0;
      if (load_move) begin
        accum    <= '0;
        velocity <= axis.increment; // Start speed of the move
      end else if (tick && executing) begin
        accum    <= accum_next;
        velocity <= velocity + axis.incr_incr;
        // Crossing of the step bit in either direction is one step
        step     <= accum_next[STEP_BIT] != accum[STEP_BIT];
      end
    end
  end

endmodule

// File: design/motion_pkg.sv
// Shared widths, command codes, register addresses and types, imported by every design module
package motion_pkg;

  localparam int WORD_BITS     = 64;
  localparam int NUM_MOTORS    = 2;
  localparam int BUFFER_SLOTS  = 2;
  localparam int SLOT_BITS     = 1;  // Index into the move buffer
  localparam int DURATION_BITS = 32;
  localparam int DDA_BITS      = 64;
  localparam int STEP_BIT      = 32; // Fixed point split of the accumulator
  localparam int DIVISOR_BITS  = 8;

  // Data words after a move header: duration, then increment and increment-increment per motor
  localparam int MOVE_WORDS      = 1 + 2 * NUM_MOTORS;
  localparam int MOVE_COUNT_BITS = $clog2(MOVE_WORDS);

  typedef logic [WORD_BITS-1:0]            word_t;
  typedef logic [7:0]                      header_t;
  typedef logic [7:0]                      reg_addr_t;
  typedef logic [DURATION_BITS-1:0]        duration_t;
  typedef logic signed [DDA_BITS-1:0]      dda_t;
  typedef logic [NUM_MOTORS-1:0]           motor_mask_t;
  typedef logic [DIVISOR_BITS-1:0]         divisor_t;
  typedef logic [SLOT_BITS-1:0]            slot_t;

  localparam header_t CMD_COORDINATED_STEP = 8'h01;
  localparam header_t CMD_STATUS_REG       = 8'hf1;
  localparam header_t CMD_CONFIG_REG       = 8'hf2;

  localparam reg_addr_t STATUS_VERSION      = 8'd0;
  localparam reg_addr_t STATUS_CHANNEL_INFO = 8'd1;
  localparam reg_addr_t CONFIG_ENABLE       = 8'd0;
  localparam reg_addr_t CONFIG_CLOCKS       = 8'd2;

  localparam logic [31:0] VERSION_WORD    = 32'h0001_0200; // Major 1, minor 2, patch 0
  localparam divisor_t    DEFAULT_DIVISOR = 8'd32;

  typedef struct packed {
    dda_t increment;
    dda_t incr_incr;
  } axis_cmd_t;

  typedef struct packed {
    motor_mask_t                     dir;
    duration_t                       duration;
    axis_cmd_t [NUM_MOTORS-1:0]      axis;
  } move_cmd_t;

  typedef enum logic [1:0] {
    idle,
    move_data,
    config_data
  } dec_state_t;

endpackage
